// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module iv_top

sim:
	verilator --binary --timing -f list.f --top-module iv_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Viv_tb

clean:
	rm -rf $(OBJ_DIR)

// File: dv/iv_tb.sv
`timescale 1ns/1ns
`include "iv_defines.svh"

module iv_tb;

	import iv_pkg::*;

	localparam int rand_cycles = 400;
	// Random cycles plus 9 per entry for up to 40 entries, doubled for margin
	localparam int cycle_limit = 2 * (rand_cycles + 9 * 40);
	localparam int enter_last = 8;		// Step that ends an entry
	localparam int ret_last = 4;		// Step that ends a return

	logic                       clk;
	logic                       rst_n;
	logic [`IV_NUM_VECTORS-1:0] irq;
	logic                       reti;
	logic                       cex_load;
	logic [7:0]                 cex_value;
	logic                       sleep;
	logic                       busy;
	logic                       entry_done;
	logic                       return_done;
	logic [2:0]                 vec_id;
	iv_state_t                  dut_state;

	logic [`IV_NUM_VECTORS-1:0] m_pend;	// Model pending bits
	logic [`IV_NUM_VECTORS-1:0] m_clr;	// Accepted bit, cleared one edge after entry starts
	iv_mode_t                   m_mode;
	int                         m_step;
	logic [2:0]                 m_vec;
	int                         m_depth;	// Nesting depth
	logic [15:0]                m_pc, m_lr, m_sp;
	psw_t                       m_psw;
	logic [7:0]                 m_cex;
	logic [15:0]                m_stack [`IV_STACK_WORDS];
	int                         cycles;
	int                         seed;

	iv_top u_iv_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.irq         (irq),
		.reti        (reti),
		.cex_load    (cex_load),
		.cex_value   (cex_value),
		.sleep       (sleep),
		.busy        (busy),
		.entry_done  (entry_done),
		.return_done (return_done),
		.vec_id      (vec_id),
		.state       (dut_state)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic push_word(input logic [15:0] w);
		m_stack[int'(m_sp) % `IV_STACK_WORDS] = w;	// Store at SP, then step down
		m_sp = m_sp - 16'd1;
	endtask

	task automatic pull_word(output logic [15:0] w);
		m_sp = m_sp + 16'd1;							// Step up, then read
		w = m_stack[int'(m_sp) % `IV_STACK_WORDS];
	endtask

	// Highest pending vector strictly above the running priority, -1 if none
	function automatic int pick_vector(input logic [`IV_NUM_VECTORS-1:0] pend, input logic [2:0] prio);
		int sel;
		sel = -1;
		for (int i = `IV_NUM_VECTORS - 1; i > int'(prio); i--) begin
			if (pend[i] && sel < 0) begin
				sel = i;
			end
		end
		return sel;
	endfunction

	task automatic enter_frame();
		push_word(m_pc);							// PC, LR, PSW, CEX in that order
		push_word(m_lr);
		push_word(m_psw);
		push_word({8'h00, m_cex});
		m_psw.prev_prio = m_psw.prio;
		m_psw.prio      = m_vec;					// Table PSW has prio = vector
		m_psw.slp       = 1'b0;
		m_pc            = `IV_ENTRY_BASE + 16'(m_vec) * `IV_ENTRY_STRIDE;
		m_lr            = `IV_LR_MAGIC;
		m_cex           = 8'h00;
		m_depth++;
	endtask

	task automatic unwind_frame();
		logic [15:0] w;
		pull_word(w);								// Reverse order of the pushes
		m_cex = w[7:0];
		pull_word(w);
		m_psw     = w;
		m_psw.slp = 1'b0;							// Return wakes the CPU
		pull_word(w);
		m_lr = w;
		pull_word(w);
		m_pc = w;
		m_depth--;
	endtask

	task automatic model_reset();
		m_pend  = '0;
		m_clr   = '0;
		m_mode  = mode_idle;
		m_step  = 0;
		m_vec   = 3'd0;
		m_depth = 0;
		m_pc    = `IV_PC_RESET;
		m_lr    = 16'h0000;
		m_sp    = `IV_SP_RESET;
		m_psw   = '0;
		m_cex   = 8'h00;
	endtask

	// One clock edge of the model, using the inputs held over the past cycle
	task automatic model_step();
		int sel;
		sel = pick_vector(m_pend, m_psw.prio);		// Uses the bits before this edge
		m_pend = (m_pend & ~m_clr) | irq;			// New strobe beats the clear
		m_clr = '0;
		if (m_mode == mode_idle) begin
			if (cex_load) begin
				m_cex = cex_value;
			end
			if (sleep) begin
				m_psw.slp = 1'b1;
			end
			if (sel >= 0) begin						// Request wins over reti
				m_mode = mode_enter;
				m_step = 0;
				m_vec  = 3'(sel);
				m_clr  = 8'h01 << sel;
			end else if (reti) begin
				m_mode = mode_ret;
				m_step = 0;
			end
		end else if (m_mode == mode_enter && m_step == enter_last) begin
			enter_frame();
			m_mode = mode_idle;
		end else if (m_mode == mode_ret && m_step == ret_last) begin
			unwind_frame();
			m_mode = mode_idle;
		end else begin
			m_step++;								// reti here is ignored
		end
	endtask

	task automatic check_state();
		check_value(dut_state.pc, m_pc, "pc");
		check_value(dut_state.lr, m_lr, "lr");
		check_value(dut_state.sp, m_sp, "sp");
		check_value(dut_state.psw, m_psw, "psw");
		check_value({8'h00, dut_state.cex}, {8'h00, m_cex}, "cex");
	endtask

	task automatic compare_outputs();
		check_value({15'h0, busy}, {15'h0, m_mode != mode_idle}, "busy");
		check_value({15'h0, entry_done}, {15'h0, m_mode == mode_enter && m_step == enter_last},
			"entry_done");
		check_value({15'h0, return_done}, {15'h0, m_mode == mode_ret && m_step == ret_last},
			"return_done");
		if (m_mode == mode_enter) begin
			check_value({13'h0, vec_id}, {13'h0, m_vec}, "vec_id");
		end
		if (m_mode == mode_idle) begin
			check_state();							// Full state only between sequences
		end
	endtask

	// Edge, model update, check 1 ns later, then strobes drop
	task automatic tick();
		@(posedge clk);
		model_step();
		#1;
		compare_outputs();
		irq      = '0;
		reti     = 1'b0;
		cex_load = 1'b0;
		sleep    = 1'b0;
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$fatal(1, "Timeout");
		end
	endtask

	// Return from every handler and serve what is still pending
	task automatic drain();
		while (m_mode != mode_idle || m_depth > 0 || m_pend[`IV_NUM_VECTORS-1:1] != '0) begin
			if (m_mode == mode_idle && m_depth > 0) begin
				reti = 1'b1;
			end
			tick();
		end
	endtask

	initial begin
		int r;
		seed      = 32'ha0f0_57b6;
		cycles    = 0;
		rst_n     = 1'b0;
		irq       = '0;
		reti      = 1'b0;
		cex_load  = 1'b0;
		cex_value = 8'h00;
		sleep     = 1'b0;
		model_reset();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		tick();
		check_value(dut_state.pc, `IV_PC_RESET, "reset pc");
		check_value(dut_state.sp, `IV_SP_RESET, "reset sp");
		check_value(dut_state.psw, 16'h0000, "reset psw");
		check_value({8'h00, dut_state.cex}, 16'h0000, "reset cex");
		check_value({15'h0, busy}, 16'h0000, "reset busy");

		irq = 8'h26;								// Vectors 1, 2 and 5 together
		repeat (12) tick();							// 5 runs, 1 and 2 wait
		cex_load  = 1'b1;							// Handler changes CEX and sleeps
		cex_value = 8'h5a;
		tick();
		sleep = 1'b1;
		tick();
		irq = 8'h80;								// Nests above vector 5
		repeat (12) tick();
		drain();

		for (int n = 0; n < rand_cycles; n++) begin
			r = $random(seed);
			if (r[3:0] == 4'd0) begin
				irq = 8'h01 << r[6:4];				// Sparse strobes
			end
			if (m_mode == mode_idle) begin
				if (m_depth > 0 && r[12:10] == 3'd0) begin
					reti = 1'b1;
				end
				if (r[15:13] == 3'd0) begin
					cex_load  = 1'b1;
					cex_value = r[23:16];
				end
				if (r[26:24] == 3'd0) begin
					sleep = 1'b1;
				end
			end else if (r[29:27] == 3'd0) begin
				reti = 1'b1;						// Dropped while busy
			end
			tick();
		end
		drain();
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: list.f
+incdir+src
src/iv_pkg.sv
src/iv_request_latch.sv
src/iv_sequencer.sv
src/iv_step_decode.sv
src/iv_stack_engine.sv
src/iv_top.sv
dv/iv_tb.sv

// File: src/iv_defines.svh
`ifndef IV_DEFINES_SVH
`define IV_DEFINES_SVH

// Interrupt vectors, vector i runs at priority i
`define IV_NUM_VECTORS 8

// Word-addressed stack, grows downward from the top word
`define IV_STACK_WORDS 64
`define IV_SP_RESET 16'd63

// Vector table rule, entry point = base + vector * stride
`define IV_ENTRY_BASE 16'h1000
`define IV_ENTRY_STRIDE 16'd32
`define IV_VEC_ENTRY(v) (`IV_ENTRY_BASE + 16'(v) * `IV_ENTRY_STRIDE)

// LR value on entry, a return through it ends the handler
`define IV_LR_MAGIC 16'hFFFF

// PC after reset
`define IV_PC_RESET 16'h0100

`endif

// File: src/iv_pkg.sv
package iv_pkg;

	// Processor status word, MSB first
	typedef struct packed {
		logic [2:0] prev_prio;	// Priority before the running handler
		logic [7:0] rsvd_hi;	// Unused
		logic       slp;		// Sleep flag
		logic [2:0] prio;		// Current CPU priority
		logic       rsvd_lo;	// Unused
	} psw_t;

	// Micro-op codes keep the CPU instruction numbers
	typedef enum logic [6:0] {
		op_mov_w = 7'd21,	// Register to register move
		op_ld_w  = 7'd33,	// Load word
		op_st_w  = 7'd34,	// Store word
		op_none  = 7'd50	// No bus operation
	} iv_op_t;

	// Register read or written by a micro-op
	typedef enum logic [3:0] {
		src_none,
		src_pc,
		src_lr,
		src_sp,
		src_psw,
		src_cex,
		src_temp,
		src_vec_psw,	// Table PSW of the taken vector
		src_vec_entry,	// Table entry point of the taken vector
		src_magic		// Constant LR end-of-handler marker
	} iv_src_t;

	// One micro-op per sequencer step
	typedef struct packed {
		iv_op_t  op;
		iv_src_t src;
		iv_src_t dst;
		logic    sp_dec;		// Post decrement SP after a push
		logic    sp_inc;		// Pre increment SP before a pull
		logic    psw_from_temp;	// Load PSW from the temp register
		logic    rec_pre_pri;	// Save the running priority
		logic    clr_slp;		// Clear PSW.slp
		logic    clear_cex;		// Zero the CEX state
		logic    load_cex;		// Load CEX from the pulled word
		logic    last;			// Final step of the sequence
	} iv_uop_t;

	// Sequencer mode
	typedef enum logic [1:0] {
		mode_idle,
		mode_enter,
		mode_ret
	} iv_mode_t;

	// Visible CPU state
	typedef struct packed {
		logic [15:0] pc;
		logic [15:0] lr;
		logic [15:0] sp;
		psw_t        psw;
		logic [7:0]  cex;
	} iv_state_t;

endpackage

// File: src/iv_request_latch.sv
`timescale 1ns/1ns
`include "iv_defines.svh"

module iv_request_latch (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`IV_NUM_VECTORS-1:0] irq,			// One-cycle request strobes
	input  logic [2:0]                 cur_prio,	// Running CPU priority
	input  logic                       accept,		// Sequencer took a vector
	input  logic [2:0]                 accept_vec,	// Vector that was taken
	output logic                       pending_valid,
	output logic [2:0]                 pending_vec
);

	logic [`IV_NUM_VECTORS-1:0] pending_q;	// Latched requests
	logic [`IV_NUM_VECTORS-1:0] pending_d;
	logic [`IV_NUM_VECTORS-1:0] clr_mask;	// Bit of the accepted vector

	// Accept clears its bit, a new strobe in the same cycle wins
	always_comb begin
		clr_mask = '0;
		if (accept) begin
			clr_mask[accept_vec] = 1'b1;
		end
		pending_d = (pending_q & ~clr_mask) | irq;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending_q <= '0;			// Nothing pending after reset
		end else begin
			pending_q <= pending_d;
		end
	end

	// Highest pending vector strictly above the running priority
	always_comb begin
		pending_valid = 1'b0;
		pending_vec   = '0;
		for (int i = 0; i < `IV_NUM_VECTORS; i++) begin
			if (pending_q[i] && (3'(i) > cur_prio)) begin
				pending_valid = 1'b1;
				pending_vec   = 3'(i);	// Later index overrides, highest wins
			end
		end
	end

endmodule

// File: src/iv_sequencer.sv
`timescale 1ns/1ns

module iv_sequencer (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             pending_valid,	// Eligible request waiting
	input  logic [2:0]       pending_vec,
	input  logic             reti,			// Return instruction strobe
	input  logic             last,			// Final step from the decoder
	output iv_pkg::iv_mode_t mode,
	output logic [3:0]       step,
	output logic             accept,		// One-cycle pulse to the latch
	output logic [2:0]       vec_id,		// Vector of the running entry
	output logic             busy,
	output logic             entry_done,
	output logic             return_done
);

	import iv_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode   <= mode_idle;
			step   <= '0;
			accept <= 1'b0;
			vec_id <= '0;
		end else begin
			accept <= 1'b0;						// Pulse only
			case (mode)
				mode_idle: begin
					step <= '0;
					if (pending_valid) begin	// Interrupt beats reti
						mode   <= mode_enter;
						vec_id <= pending_vec;	// Hold vector for the table lookup
						accept <= 1'b1;
					end else if (reti) begin
						mode <= mode_ret;
					end
				end
				default: begin					// Entry or return in progress
					if (last) begin
						mode <= mode_idle;
						step <= '0;
					end else begin
						step <= step + 4'd1;
					end
				end
			endcase
		end
	end

	// Status straight from the state and the decoded last step
	assign busy        = (mode != mode_idle);
	assign entry_done  = (mode == mode_enter) && last;
	assign return_done = (mode == mode_ret) && last;

endmodule

// File: src/iv_stack_engine.sv
`timescale 1ns/1ns
`include "iv_defines.svh"

module iv_stack_engine (
	input  logic              clk,
	input  logic              rst_n,
	input  iv_pkg::iv_uop_t   uop,
	input  logic [2:0]        vec_id,		// Vector table index
	input  logic              cex_load,		// External CEX instruction
	input  logic [7:0]        cex_value,
	input  logic              sleep,		// Sets PSW.slp
	output iv_pkg::iv_state_t state
);

	import iv_pkg::*;

	localparam int stk_aw = $clog2(`IV_STACK_WORDS);

	logic [15:0]     pc_q, lr_q, sp_q;
	psw_t            psw_q;
	logic [7:0]      cex_q;
	logic [15:0]     temp_q;					// Table PSW during entry
	logic [2:0]      saved_prio_q;				// Priority before entry
	logic [15:0]     stack_mem [`IV_STACK_WORDS];
	psw_t            vec_psw;
	logic [15:0]     vec_entry;
	logic [stk_aw-1:0] push_idx, pull_idx;
	logic [15:0]     src_val;					// Selected source word
	logic [15:0]     pull_val;					// Word above SP
	logic [15:0]     wr_val;
	logic            ext_ok;					// No bus operation this step

	// Vector table built from the vector number
	always_comb begin
		vec_psw      = '0;
		vec_psw.prio = vec_id;
	end
	assign vec_entry = `IV_VEC_ENTRY(vec_id);

	assign push_idx = sp_q[stk_aw-1:0];			// Store at SP
	assign pull_idx = push_idx + stk_aw'(1);	// Load from SP + 1
	assign pull_val = stack_mem[pull_idx];

	always_comb begin
		case (uop.src)
			src_pc:        src_val = pc_q;
			src_lr:        src_val = lr_q;
			src_sp:        src_val = sp_q;
			src_psw:       src_val = psw_q;
			src_cex:       src_val = {8'h00, cex_q};
			src_temp:      src_val = temp_q;
			src_vec_psw:   src_val = vec_psw;
			src_vec_entry: src_val = vec_entry;
			src_magic:     src_val = `IV_LR_MAGIC;
			default:       src_val = 16'h0000;
		endcase
	end

	// Pulls take the stack word and other writes take the source
	assign wr_val = uop.sp_inc ? pull_val : src_val;
	assign ext_ok = (uop.op == op_none);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q  <= `IV_PC_RESET;
			lr_q  <= 16'h0000;
			sp_q  <= `IV_SP_RESET;
			psw_q <= '0;
			cex_q <= 8'h00;
		end else begin
			if (ext_ok && cex_load) begin
				cex_q <= cex_value;
			end
			if (ext_ok && sleep) begin
				psw_q.slp <= 1'b1;
			end
			if (uop.op == op_ld_w || uop.op == op_mov_w) begin
				case (uop.dst)
					src_pc:   pc_q  <= wr_val;
					src_lr:   lr_q  <= wr_val;
					src_psw:  psw_q <= wr_val;
					src_cex:  cex_q <= wr_val[7:0];
					default: ;					// Temp has its own register
				endcase
			end
			if (uop.sp_dec) begin
				sp_q <= sp_q - 16'd1;
			end
			if (uop.sp_inc) begin
				sp_q <= sp_q + 16'd1;
			end
			if (uop.load_cex) begin
				cex_q <= pull_val[7:0];
			end
			if (uop.psw_from_temp) begin
				psw_q           <= temp_q;
				psw_q.prev_prio <= saved_prio_q;
			end
			if (uop.clr_slp) begin
				psw_q.slp <= 1'b0;
			end
			if (uop.clear_cex) begin
				cex_q <= 8'h00;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (uop.op == op_st_w) begin
			stack_mem[push_idx] <= src_val;
		end
		if (uop.op == op_ld_w && uop.dst == src_temp) begin
			temp_q <= src_val;
		end
		if (uop.rec_pre_pri) begin
			saved_prio_q <= psw_q.prio;
		end
	end

	assign state = '{pc: pc_q, lr: lr_q, sp: sp_q, psw: psw_q, cex: cex_q};

endmodule

// File: src/iv_step_decode.sv
`timescale 1ns/1ns

module iv_step_decode (
	input  iv_pkg::iv_mode_t mode,
	input  logic [3:0]       step,
	output iv_pkg::iv_uop_t  uop
);

	import iv_pkg::*;

	always_comb begin
		uop.op            = op_none;	// No bus operation
		uop.src           = src_none;
		uop.dst           = src_none;
		uop.sp_dec        = 1'b0;
		uop.sp_inc        = 1'b0;
		uop.psw_from_temp = 1'b0;
		uop.rec_pre_pri   = 1'b0;
		uop.clr_slp       = 1'b0;
		uop.clear_cex     = 1'b0;
		uop.load_cex      = 1'b0;
		uop.last          = 1'b0;
		if (mode == mode_enter) begin
			case (step)
				4'd0: begin					// Vector PSW into temp
					uop.op  = op_ld_w;
					uop.src = src_vec_psw;
					uop.dst = src_temp;
				end
				4'd1: begin					// Push PC
					uop.op     = op_st_w;
					uop.src    = src_pc;
					uop.sp_dec = 1'b1;
				end
				4'd2: begin					// Push LR
					uop.op     = op_st_w;
					uop.src    = src_lr;
					uop.sp_dec = 1'b1;
				end
				4'd3: begin					// Push PSW
					uop.op     = op_st_w;
					uop.src    = src_psw;
					uop.sp_dec = 1'b1;
				end
				4'd4: begin					// Push CEX, keep the old priority
					uop.op          = op_st_w;
					uop.src         = src_cex;
					uop.sp_dec      = 1'b1;
					uop.rec_pre_pri = 1'b1;
				end
				4'd5: begin
					// New PSW from the table, with prev_prio filled in and slp cleared
					uop.src           = src_temp;
					uop.dst           = src_psw;
					uop.psw_from_temp = 1'b1;
					uop.clr_slp       = 1'b1;
				end
				4'd6: begin					// Jump to the handler
					uop.op  = op_ld_w;
					uop.src = src_vec_entry;
					uop.dst = src_pc;
				end
				4'd7: begin					// LR gets the end marker
					uop.op  = op_mov_w;
					uop.src = src_magic;
					uop.dst = src_lr;
				end
				4'd8: begin					// Fresh CEX state, done
					uop.clear_cex = 1'b1;
					uop.last      = 1'b1;
				end
				default: ;
			endcase
		end else if (mode == mode_ret) begin
			case (step)
				4'd0: begin					// Pull CEX
					uop.op       = op_ld_w;
					uop.sp_inc   = 1'b1;
					uop.load_cex = 1'b1;
				end
				4'd1: begin					// Pull PSW
					uop.op     = op_ld_w;
					uop.dst    = src_psw;
					uop.sp_inc = 1'b1;
				end
				4'd2: begin					// Wake up
					uop.clr_slp = 1'b1;
				end
				4'd3: begin					// Pull LR
					uop.op     = op_ld_w;
					uop.dst    = src_lr;
					uop.sp_inc = 1'b1;
				end
				4'd4: begin					// Pull PC, done
					uop.op     = op_ld_w;
					uop.dst    = src_pc;
					uop.sp_inc = 1'b1;
					uop.last   = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: src/iv_top.sv
`timescale 1ns/1ns
`include "iv_defines.svh"

module iv_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`IV_NUM_VECTORS-1:0] irq,			// Interrupt strobes
	input  logic                       reti,		// Return from handler
	input  logic                       cex_load,
	input  logic [7:0]                 cex_value,
	input  logic                       sleep,
	output logic                       busy,
	output logic                       entry_done,
	output logic                       return_done,
	output logic [2:0]                 vec_id,
	output iv_pkg::iv_state_t          state
);

	import iv_pkg::*;

	logic       pending_valid;
	logic [2:0] pending_vec;
	logic       accept;
	iv_mode_t   mode;
	logic [3:0] step;
	iv_uop_t    uop;

	iv_request_latch u_iv_request_latch (
		.clk           (clk),
		.rst_n         (rst_n),
		.irq           (irq),
		.cur_prio      (state.psw.prio),	// Running priority gates requests
		.accept        (accept),
		.accept_vec    (vec_id),
		.pending_valid (pending_valid),
		.pending_vec   (pending_vec)
	);

	iv_sequencer u_iv_sequencer (
		.clk           (clk),
		.rst_n         (rst_n),
		.pending_valid (pending_valid),
		.pending_vec   (pending_vec),
		.reti          (reti),
		.last          (uop.last),
		.mode          (mode),
		.step          (step),
		.accept        (accept),
		.vec_id        (vec_id),
		.busy          (busy),
		.entry_done    (entry_done),
		.return_done   (return_done)
	);

	iv_step_decode u_iv_step_decode (
		.mode (mode),
		.step (step),
		.uop  (uop)
	);

	iv_stack_engine u_iv_stack_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.uop       (uop),
		.vec_id    (vec_id),
		.cex_load  (cex_load),
		.cex_value (cex_value),
		.sleep     (sleep),
		.state     (state)
	);

endmodule
